// ==== Bender.yml ====
package:
  name: hyperbus_phy

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hyperbus_trans_pkg.sv
      - rtl/hyperbus_bus_pkg.sv
      - rtl/cmd_addr_gen.sv
      - rtl/hyperbus_tx_buffer.sv
      - rtl/hyperbus_read_fifo.sv
      - rtl/hyperbus_phy.sv
      - rtl/hyperbus_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/hyperram_model.sv
      - bench/tb_hyperbus.sv

// ==== all.f ====
+incdir+rtl
rtl/hyperbus_trans_pkg.sv
rtl/hyperbus_bus_pkg.sv
rtl/cmd_addr_gen.sv
rtl/hyperbus_tx_buffer.sv
rtl/hyperbus_read_fifo.sv
rtl/hyperbus_phy.sv
rtl/hyperbus_top.sv
bench/hyperram_model.sv
bench/tb_hyperbus.sv

// ==== bench/hyperram_model.sv ====
// behavioral HyperRAM pair, 256 words per chip, linear bursts only
// chips flagged in extra_lat_cs always ask for doubled latency
`timescale 1ns/1ps
`include "hyperbus_cfg.svh"

module hyperram_model #(
    parameter hyperbus_trans_pkg::hb_cs_t extra_lat_cs = 2'b10
) (
    input  logic                          clk0,
    input  hyperbus_bus_pkg::hb_pad_out_t bus_i,
    output hyperbus_bus_pkg::hb_pad_in_t  bus_o
);

    localparam int unsigned lat = `HB_WAIT_CYCLES;

    hyperbus_trans_pkg::hb_word_t mem [512]; // chip in bit 8
    hyperbus_trans_pkg::hb_word_t cfg_reg [2];
    hyperbus_bus_pkg::hb_ca_t     ca;
    int unsigned                  ck_cnt; // clocked cycles since cs fell
    int unsigned                  data_start;
    logic                         active;
    logic                         chip;
    logic                         data_phase;
    logic [8:0]                   idx;

    assign active = !(&bus_i.cs_n);
    assign chip   = ~bus_i.cs_n[1]; // two chips only

    // register writes go without latency
    assign data_start = (ca[46] && !ca[47]) ? 3
                      : (extra_lat_cs[chip] ? 3 + 2 * lat : 3 + lat);
    assign data_phase = active && ck_cnt >= data_start;
    assign idx = {chip, 8'({ca[44:16], ca[2:0]} + 32'(ck_cnt - data_start))};

    always_comb begin
        bus_o = '0;
        if (active && ck_cnt < 3) begin
            bus_o.rwds = {extra_lat_cs[chip], 1'b0}; // latency request
        end else if (data_phase && ca[47] && bus_i.ck_en) begin
            bus_o.rwds = 2'b10;
            bus_o.dq   = ca[46] ? cfg_reg[chip] : mem[idx];
        end
    end

    always_ff @(posedge clk0) begin
        if (!active) begin
            ck_cnt <= 0;
        end else if (bus_i.ck_en) begin
            ck_cnt <= ck_cnt + 1;
            if (ck_cnt < 3) begin
                ca[47 - 16 * ck_cnt -: 16] <= bus_i.dq;
            end else if (data_phase && !ca[47]) begin
                if (ca[46]) begin
                    cfg_reg[chip] <= bus_i.dq;
                end else begin
                    // rwds high masks the byte
                    if (!bus_i.rwds[1]) mem[idx][15:8] <= bus_i.dq[15:8];
                    if (!bus_i.rwds[0]) mem[idx][7:0] <= bus_i.dq[7:0];
                end
            end
        end
    end

endmodule

// ==== bench/tb_hyperbus.sv ====
// testbench for the HyperBus subsystem against a two-chip HyperRAM model
// chip 1 of the model asks for doubled latency, test addresses stay below 256
`timescale 1ns/1ps

module tb_hyperbus;

    localparam int limit = 200; // cycles per wait

    logic                          clk0 = 1'b0;
    logic                          rst_ni;
    logic                          trans_valid_i, trans_ready_o;
    hyperbus_trans_pkg::hb_trans_t trans_i;
    logic                          tx_valid_i, tx_ready_o;
    hyperbus_trans_pkg::hb_word_t  tx_data_i;
    hyperbus_trans_pkg::hb_strb_t  tx_strb_i;
    logic                          rx_valid_o, rx_ready_i;
    hyperbus_trans_pkg::hb_word_t  rx_data_o;
    hyperbus_bus_pkg::hb_pad_out_t pad_o;
    hyperbus_bus_pkg::hb_pad_in_t  pad_i;

    hyperbus_trans_pkg::hb_word_t ref_mem [512]; // chip in bit 8
    hyperbus_trans_pkg::hb_word_t ref_cfg [2];
    hyperbus_trans_pkg::hb_cs_t   cur_cs = '0;
    logic [31:0]                  rng = 32'h13e4_acf7;
    logic                         started = 1'b0;
    int                           value_errs = 0;
    int                           proto_errs = 0;

    always #20 clk0 = ~clk0;

    hyperbus_top u_hyperbus_top (.*);

    hyperram_model #(.extra_lat_cs(2'b10)) u_hyperram (
        .clk0  ( clk0  ),
        .bus_i ( pad_o ),
        .bus_o ( pad_i )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [8:0] ref_idx(input int chip, input logic [31:0] addr, input int i);
        return {chip[0], 8'(addr[7:0] + i)};
    endfunction

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic issue_trans(input int chip, input logic wr, input logic rs,
                               input logic [31:0] addr, input int len);
        int   t;
        logic hit;
        @(negedge clk0);
        trans_valid_i     = 1'b1;
        trans_i.address   = addr;
        trans_i.cs        = hyperbus_trans_pkg::hb_cs_t'(1 << chip);
        trans_i.write     = wr;
        trans_i.burst     = hyperbus_trans_pkg::hb_burst_t'(len);
        trans_i.reg_space = rs;
        t   = 0;
        hit = 1'b0;
        while (!hit) begin
            @(posedge clk0);
            hit = trans_ready_o;
            t++;
            if (!hit && t == limit) abort_run("transaction acceptance");
        end
        cur_cs  = trans_i.cs; // bus still idle here
        started = 1'b1;
        @(negedge clk0);
        trans_valid_i = 1'b0;
    endtask

    task automatic write_burst(input int chip, input logic rs, input logic [31:0] addr,
                               input int len, input logic rand_strb);
        int                           t;
        logic                         hit;
        logic [8:0]                   k;
        hyperbus_trans_pkg::hb_word_t d;
        hyperbus_trans_pkg::hb_strb_t s;
        issue_trans(chip, 1'b1, rs, addr, len);
        for (int i = 0; i < len; i++) begin
            d = hyperbus_trans_pkg::hb_word_t'(next_rand());
            s = rand_strb ? hyperbus_trans_pkg::hb_strb_t'(next_rand()) : 2'b11;
            if ((next_rand() & 32'h7) == 0) begin // occasional bubble
                tx_valid_i = 1'b0;
                @(negedge clk0);
            end
            tx_valid_i = 1'b1;
            tx_data_i  = d;
            tx_strb_i  = s;
            t   = 0;
            hit = 1'b0;
            while (!hit) begin
                @(posedge clk0);
                hit = tx_ready_o;
                t++;
                if (!hit && t == limit) abort_run("write data");
            end
            k = ref_idx(chip, addr, i);
            if (rs) ref_cfg[chip] = d;
            if (!rs && s[1]) ref_mem[k][15:8] = d[15:8]; // strobed bytes only
            if (!rs && s[0]) ref_mem[k][7:0] = d[7:0];
            @(negedge clk0);
        end
        tx_valid_i = 1'b0;
    endtask

    task automatic read_check(input int chip, input logic rs, input logic [31:0] addr,
                              input int len, input logic rand_ready, input string name);
        int                           t;
        logic                         hit;
        hyperbus_trans_pkg::hb_word_t exp;
        hyperbus_trans_pkg::hb_word_t got;
        issue_trans(chip, 1'b0, rs, addr, len);
        for (int i = 0; i < len; i++) begin
            exp = rs ? ref_cfg[chip] : ref_mem[ref_idx(chip, addr, i)];
            t   = 0;
            hit = 1'b0;
            while (!hit) begin
                rx_ready_i = rand_ready ? (next_rand() & 32'h8) != 0 : 1'b1;
                @(posedge clk0);
                hit = rx_valid_o && rx_ready_i;
                got = rx_data_o;
                t++;
                if (!hit && t == limit) abort_run("read data");
                @(negedge clk0);
            end
            assert (got == exp)
                else begin
                    value_errs++;
                    $display("[FAIL] %s word %0d: expected %h, actual %h", name, i, exp, got);
                end
        end
        rx_ready_i = 1'b0;
    endtask

    assert property (@(posedge clk0) !rst_ni |-> !trans_ready_o && !tx_ready_o && !rx_valid_o
        && &pad_o.cs_n && !pad_o.ck_en && !pad_o.dq_oe && !pad_o.rwds_oe)
        else begin
            proto_errs++;
            $display("outputs active while reset is asserted");
        end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        !started |-> !pad_o.ck_en && &pad_o.cs_n)
        else begin
            proto_errs++;
            $display("bus active before the first transaction");
        end

    // only the chip of the current transaction may be selected
    assert property (@(posedge clk0) disable iff (!rst_ni)
        !(&pad_o.cs_n) |-> pad_o.cs_n == ~cur_cs)
        else begin
            proto_errs++;
            $display("chip select does not match the transaction");
        end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o))
        else begin
            proto_errs++;
            $display("read word dropped or changed before it was taken");
        end

    initial begin
        logic [31:0] a2, a3, a4;
        int          n2, n4;
        rst_ni        = 1'b0;
        trans_valid_i = 1'b0;
        trans_i       = '0;
        tx_valid_i    = 1'b0;
        tx_data_i     = '0;
        tx_strb_i     = '0;
        rx_ready_i    = 1'b0;
        repeat (8) @(negedge clk0);
        rst_ni = 1'b1;
        repeat (4) @(negedge clk0); // bus must stay idle

        a2 = next_rand() & 32'hf8;
        n2 = 1 + int'(next_rand() % 8);
        write_burst(0, 1'b0, a2, n2, 1'b0);
        read_check(0, 1'b0, a2, n2, 1'b0, "chip0_round_trip");

        a3 = next_rand() & 32'hf8;
        write_burst(0, 1'b0, a3, 8, 1'b0);
        write_burst(0, 1'b0, a3, 8, 1'b1);
        read_check(0, 1'b0, a3, 8, 1'b0, "strobed_write");

        a4 = next_rand() & 32'hf8;
        n4 = 1 + int'(next_rand() % 8);
        write_burst(1, 1'b0, a4, n4, 1'b0);
        read_check(1, 1'b0, a4, n4, 1'b0, "chip1_extra_latency");

        // register access at a2, so the memory read below covers that word
        write_burst(0, 1'b1, a2, 1, 1'b0);
        read_check(0, 1'b1, a2, 1, 1'b0, "register_round_trip");
        read_check(0, 1'b0, a2, n2, 1'b0, "memory_after_register");

        read_check(0, 1'b0, a3, 8, 1'b1, "rx_backpressure");

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/cmd_addr_gen.sv ====
// command/address word for one captured transaction
// bursts are always linear, reserved bits 15:3 go out as zero
`timescale 1ns/1ps

module cmd_addr_gen (
    input  hyperbus_trans_pkg::hb_trans_t trans_i,
    output hyperbus_bus_pkg::hb_ca_t      ca_o
);

    always_comb begin
        ca_o        = '0;
        ca_o[47]    = ~trans_i.write;     // read not write
        ca_o[46]    = trans_i.reg_space;
        ca_o[45]    = 1'b1;               // linear burst
        ca_o[44:16] = trans_i.address[31:3];
        ca_o[2:0]   = trans_i.address[2:0];
    end

    // a linear burst must end below the top of the 32-bit address space
    always_comb begin
        assert final ($isunknown(trans_i)
                      || 33'(trans_i.address) + 33'(trans_i.burst) <= 33'h1_0000_0000)
            else $error("ca word drops address bits");
    end

endmodule

// ==== rtl/hyperbus_bus_pkg.sv ====
// bus-side types of the HyperBus PHY
// the pad structs replace the DDR cells and tristate pads
package hyperbus_bus_pkg;

    // 47 r/w#, 46 space, 45 burst type, 44:16 upper addr, 2:0 lower addr
    typedef logic [47:0] hb_ca_t;

    typedef enum logic [3:0] {
        STANDBY, SET_CA, CA, REG_WRITE, WAIT_EXTRA, WAIT_ACC,
        DATA_W, WAIT_W, DATA_R, WAIT_R, RECOVER
    } hb_state_e;

    typedef struct packed {
        hyperbus_trans_pkg::hb_cs_t   cs_n;
        logic                         ck_en; // bus clock runs while high
        hyperbus_trans_pkg::hb_word_t dq;
        logic                         dq_oe;
        logic [1:0]                   rwds; // rising, falling edge
        logic                         rwds_oe;
    } hb_pad_out_t;

    typedef struct packed {
        hyperbus_trans_pkg::hb_word_t dq;
        logic [1:0]                   rwds;
    } hb_pad_in_t;

endpackage

// ==== rtl/hyperbus_cfg.svh ====
// build-time configuration of the HyperBus subsystem
// HB_RX_DEPTH must be a power of two, HB_WAIT_CYCLES at least 1
`ifndef HYPERBUS_CFG_SVH
`define HYPERBUS_CFG_SVH

// burst length field, in 16-bit words
`define HB_BURST_WIDTH 12

// one-hot chip selects
`define HB_NR_CS 2

// initial latency in clk0 cycles, doubled on request
`define HB_WAIT_CYCLES 6

`define HB_RX_DEPTH 4 // read fifo entries

`endif

// ==== rtl/hyperbus_phy.sv ====
// transaction FSM of the HyperBus PHY, one 16-bit word per clk0 cycle
// read data is expected in the same cycle as its ck_en, marked rwds = 2'b10
// register writes need their tx word, the bus clock waits for it
`timescale 1ns/1ps
`include "hyperbus_cfg.svh"

module hyperbus_phy (
    input  logic                          clk0,
    input  logic                          rst_ni,
    input  logic                          trans_valid_i,
    output logic                          trans_ready_o,
    input  hyperbus_trans_pkg::hb_trans_t trans_i,
    input  logic                          tx_valid_i,
    output logic                          tx_ready_o,
    input  hyperbus_trans_pkg::hb_word_t  tx_data_i,
    input  hyperbus_trans_pkg::hb_strb_t  tx_strb_i,
    output logic                          rx_valid_o,
    input  logic                          rx_ready_i,
    output hyperbus_trans_pkg::hb_word_t  rx_data_o,
    output hyperbus_bus_pkg::hb_pad_out_t pad_o,
    input  hyperbus_bus_pkg::hb_pad_in_t  pad_i
);

    localparam int unsigned wait_w = $clog2(`HB_WAIT_CYCLES) + 1;

    hyperbus_bus_pkg::hb_state_e    state;
    hyperbus_trans_pkg::hb_trans_t  local_trans;
    hyperbus_trans_pkg::hb_burst_t  burst_cnt;
    hyperbus_bus_pkg::hb_ca_t       ca;
    hyperbus_trans_pkg::hb_word_t   ca_word;
    logic [wait_w-1:0]              wait_cnt;
    logic [1:0]                     ca_idx;
    logic                           fifo_afull;
    logic                           fifo_empty;

    cmd_addr_gen i_cmd_addr_gen (
        .trans_i ( local_trans ),
        .ca_o    ( ca          )
    );

    hyperbus_read_fifo i_read_fifo (
        .clk0          ( clk0                                          ),
        .rst_ni        ( rst_ni                                        ),
        .capture_en_i  ( state == hyperbus_bus_pkg::DATA_R             ),
        .flush_i       ( state == hyperbus_bus_pkg::RECOVER && local_trans.write ),
        .pad_i         ( pad_i                                         ),
        .almost_full_o ( fifo_afull                                    ),
        .empty_o       ( fifo_empty                                    ),
        .rx_valid_o    ( rx_valid_o                                    ),
        .rx_ready_i    ( rx_ready_i                                    ),
        .rx_data_o     ( rx_data_o                                     )
    );

    assign trans_ready_o = state == hyperbus_bus_pkg::STANDBY && trans_valid_i;

    always_ff @(posedge clk0) begin
        if (trans_ready_o) begin
            local_trans <= trans_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state     <= hyperbus_bus_pkg::STANDBY;
            wait_cnt  <= '0;
            burst_cnt <= '0;
            ca_idx    <= '0;
        end else begin
            unique case (state)
                hyperbus_bus_pkg::STANDBY: begin
                    if (trans_ready_o) begin
                        state     <= hyperbus_bus_pkg::SET_CA;
                        burst_cnt <= trans_i.burst - 1'b1;
                        ca_idx    <= '0;
                    end
                end
                hyperbus_bus_pkg::SET_CA: state <= hyperbus_bus_pkg::CA;
                hyperbus_bus_pkg::CA: begin
                    ca_idx   <= ca_idx + 1'b1;
                    wait_cnt <= wait_w'(`HB_WAIT_CYCLES - 1);
                    if (ca_idx == 2'd2) begin
                        if (local_trans.reg_space && local_trans.write) begin
                            state <= hyperbus_bus_pkg::REG_WRITE; // zero latency
                        end else if (pad_i.rwds[1]) begin
                            state <= hyperbus_bus_pkg::WAIT_EXTRA;
                        end else begin
                            state <= hyperbus_bus_pkg::WAIT_ACC;
                        end
                    end
                end
                hyperbus_bus_pkg::REG_WRITE: begin
                    if (tx_valid_i) state <= hyperbus_bus_pkg::RECOVER;
                end
                hyperbus_bus_pkg::WAIT_EXTRA: begin
                    if (wait_cnt == '0) begin
                        wait_cnt <= wait_w'(`HB_WAIT_CYCLES - 1);
                        state    <= hyperbus_bus_pkg::WAIT_ACC;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                hyperbus_bus_pkg::WAIT_ACC: begin
                    if (wait_cnt == '0) begin
                        state <= local_trans.write ? hyperbus_bus_pkg::DATA_W
                                                   : hyperbus_bus_pkg::DATA_R;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                hyperbus_bus_pkg::DATA_W: begin
                    if (tx_valid_i) begin
                        burst_cnt <= burst_cnt - 1'b1;
                        if (burst_cnt == '0) begin
                            wait_cnt <= wait_w'(`HB_WAIT_CYCLES - 1);
                            state    <= hyperbus_bus_pkg::RECOVER;
                        end
                    end else begin
                        state <= hyperbus_bus_pkg::WAIT_W;
                    end
                end
                hyperbus_bus_pkg::WAIT_W: begin
                    if (tx_valid_i) state <= hyperbus_bus_pkg::DATA_W;
                end
                hyperbus_bus_pkg::DATA_R: begin
                    burst_cnt <= burst_cnt - 1'b1; // one word per clocked cycle
                    if (burst_cnt == '0) begin
                        wait_cnt <= wait_w'(`HB_WAIT_CYCLES - 1);
                        state    <= hyperbus_bus_pkg::RECOVER;
                    end else if (fifo_afull) begin
                        state <= hyperbus_bus_pkg::WAIT_R;
                    end
                end
                hyperbus_bus_pkg::WAIT_R: begin
                    if (!fifo_afull) state <= hyperbus_bus_pkg::DATA_R;
                end
                hyperbus_bus_pkg::RECOVER: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else if (fifo_empty) begin
                        state <= hyperbus_bus_pkg::STANDBY; // host drained all reads
                    end
                end
                default: state <= hyperbus_bus_pkg::STANDBY;
            endcase
        end
    end

    always_comb begin
        unique case (ca_idx)
            2'd0:    ca_word = ca[47:32];
            2'd1:    ca_word = ca[31:16];
            default: ca_word = ca[15:0];
        endcase
    end

    always_comb begin
        pad_o      = '0;
        tx_ready_o = 1'b0;
        pad_o.cs_n = state inside {hyperbus_bus_pkg::STANDBY, hyperbus_bus_pkg::RECOVER}
                     ? '1 : ~local_trans.cs;
        unique case (state)
            hyperbus_bus_pkg::CA: begin
                pad_o.ck_en = 1'b1;
                pad_o.dq_oe = 1'b1;
                pad_o.dq    = ca_word;
            end
            hyperbus_bus_pkg::REG_WRITE: begin
                pad_o.ck_en = tx_valid_i;
                pad_o.dq_oe = 1'b1;
                pad_o.dq    = tx_data_i;
                tx_ready_o  = 1'b1;
            end
            hyperbus_bus_pkg::WAIT_EXTRA, hyperbus_bus_pkg::WAIT_ACC,
            hyperbus_bus_pkg::DATA_R: begin
                pad_o.ck_en = 1'b1;
            end
            hyperbus_bus_pkg::DATA_W, hyperbus_bus_pkg::WAIT_W: begin
                pad_o.ck_en   = state == hyperbus_bus_pkg::DATA_W && tx_valid_i;
                pad_o.dq_oe   = 1'b1;
                pad_o.dq      = tx_data_i;
                pad_o.rwds_oe = 1'b1;
                pad_o.rwds    = ~tx_strb_i; // high masks a byte
                tx_ready_o    = state == hyperbus_bus_pkg::DATA_W;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        !(&pad_o.cs_n) |-> $onehot(~pad_o.cs_n))
        else $error("more than one chip selected");

    // reads release dq once the command is out
    assert property (@(posedge clk0) disable iff (!rst_ni)
        state inside {hyperbus_bus_pkg::WAIT_R, hyperbus_bus_pkg::RECOVER}
            || (!local_trans.write && state != hyperbus_bus_pkg::CA)
        |-> !pad_o.dq_oe)
        else $error("dq driven while the memory owns the bus");

endmodule

// ==== rtl/hyperbus_read_fifo.sv ====
// read data fifo, fed by words qualified with rwds = 2'b10
// almost full leaves room for the one word still on the bus
`timescale 1ns/1ps
`include "hyperbus_cfg.svh"

module hyperbus_read_fifo (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  logic                         capture_en_i,
    input  logic                         flush_i,
    input  hyperbus_bus_pkg::hb_pad_in_t pad_i,
    output logic                         almost_full_o,
    output logic                         empty_o,
    output logic                         rx_valid_o,
    input  logic                         rx_ready_i,
    output hyperbus_trans_pkg::hb_word_t rx_data_o
);

    localparam int unsigned depth = `HB_RX_DEPTH;
    localparam int unsigned ptr_w = $clog2(depth);
    localparam int unsigned cnt_w = ptr_w + 1;

    hyperbus_trans_pkg::hb_word_t mem [depth];
    logic [ptr_w-1:0] wptr, rptr;
    logic [cnt_w-1:0] count;
    logic push, pop;

    assign push = capture_en_i && pad_i.rwds == 2'b10;
    assign pop  = rx_valid_o && rx_ready_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (flush_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) wptr <= wptr + 1'b1; // wraps, depth is 2**n
            if (pop) rptr <= rptr + 1'b1;
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk0) begin
        if (push) begin
            mem[wptr] <= pad_i.dq;
        end
    end

    assign empty_o       = count == '0;
    assign almost_full_o = count >= cnt_w'(depth - 1);
    assign rx_valid_o    = !empty_o;
    assign rx_data_o     = mem[rptr];

    // the phy must stop the bus clock in time
    assert property (@(posedge clk0) disable iff (!rst_ni)
        push |-> count != cnt_w'(depth))
        else $error("read word pushed into a full fifo");

endmodule

// ==== rtl/hyperbus_top.sv ====
// HyperBus subsystem top, pads as structs with output enables
`timescale 1ns/1ps

module hyperbus_top (
    input  logic                          clk0,
    input  logic                          rst_ni,
    input  logic                          trans_valid_i,
    output logic                          trans_ready_o,
    input  hyperbus_trans_pkg::hb_trans_t trans_i,
    input  logic                          tx_valid_i,
    output logic                          tx_ready_o,
    input  hyperbus_trans_pkg::hb_word_t  tx_data_i,
    input  hyperbus_trans_pkg::hb_strb_t  tx_strb_i,
    output logic                          rx_valid_o,
    input  logic                          rx_ready_i,
    output hyperbus_trans_pkg::hb_word_t  rx_data_o,
    output hyperbus_bus_pkg::hb_pad_out_t pad_o,
    input  hyperbus_bus_pkg::hb_pad_in_t  pad_i
);

    logic                         buf_valid, buf_ready;
    hyperbus_trans_pkg::hb_word_t buf_data;
    hyperbus_trans_pkg::hb_strb_t buf_strb;

    hyperbus_tx_buffer i_tx_buffer (
        .clk0        ( clk0       ),
        .rst_ni      ( rst_ni     ),
        .in_valid_i  ( tx_valid_i ),
        .in_ready_o  ( tx_ready_o ),
        .in_data_i   ( tx_data_i  ),
        .in_strb_i   ( tx_strb_i  ),
        .out_valid_o ( buf_valid  ),
        .out_ready_i ( buf_ready  ),
        .out_data_o  ( buf_data   ),
        .out_strb_o  ( buf_strb   )
    );

    hyperbus_phy i_phy (
        .clk0          ( clk0          ),
        .rst_ni        ( rst_ni        ),
        .trans_valid_i ( trans_valid_i ),
        .trans_ready_o ( trans_ready_o ),
        .trans_i       ( trans_i       ),
        .tx_valid_i    ( buf_valid     ),
        .tx_ready_o    ( buf_ready     ),
        .tx_data_i     ( buf_data      ),
        .tx_strb_i     ( buf_strb      ),
        .rx_valid_o    ( rx_valid_o    ),
        .rx_ready_i    ( rx_ready_i    ),
        .rx_data_o     ( rx_data_o     ),
        .pad_o         ( pad_o         ),
        .pad_i         ( pad_i         )
    );

endmodule

// ==== rtl/hyperbus_trans_pkg.sv ====
// host-side transaction types
// addresses are word addresses, bursts are counted in 16-bit words
`include "hyperbus_cfg.svh"

package hyperbus_trans_pkg;

    typedef logic [31:0] hb_addr_t;

    // zero length is illegal
    typedef logic [`HB_BURST_WIDTH-1:0] hb_burst_t;

    typedef logic [`HB_NR_CS-1:0] hb_cs_t; // one-hot

    typedef logic [15:0] hb_word_t; // high byte goes out on the rising edge

    // bit 1 covers the high byte
    typedef logic [1:0] hb_strb_t;

    typedef struct packed {
        hb_addr_t  address;
        hb_cs_t    cs;
        logic      write;
        hb_burst_t burst;
        logic      reg_space; // register space instead of memory
    } hb_trans_t;

endpackage

// ==== rtl/hyperbus_tx_buffer.sv ====
// two-entry skid buffer on the write stream
// ready is registered, low for the first cycle after reset
`timescale 1ns/1ps

module hyperbus_tx_buffer (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  hyperbus_trans_pkg::hb_word_t in_data_i,
    input  hyperbus_trans_pkg::hb_strb_t in_strb_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output hyperbus_trans_pkg::hb_word_t out_data_o,
    output hyperbus_trans_pkg::hb_strb_t out_strb_o
);

    logic skid_valid;
    logic ready_q;
    hyperbus_trans_pkg::hb_word_t skid_data;
    hyperbus_trans_pkg::hb_strb_t skid_strb;
    logic to_out, to_skid, from_skid, skid_keep;

    assign in_ready_o = ready_q;
    assign to_out     = in_valid_i && in_ready_o && (!out_valid_o || out_ready_i);
    assign to_skid    = in_valid_i && in_ready_o && out_valid_o && !out_ready_i;
    assign from_skid  = skid_valid && out_ready_i;
    assign skid_keep  = skid_valid && !out_ready_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_o <= 1'b0;
            skid_valid  <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            out_valid_o <= to_out || from_skid || (out_valid_o && !out_ready_i);
            skid_valid  <= to_skid || skid_keep;
            ready_q     <= !(to_skid || skid_keep); // space left next cycle
        end
    end

    always_ff @(posedge clk0) begin
        if (from_skid) begin
            out_data_o <= skid_data;
            out_strb_o <= skid_strb;
        end else if (to_out) begin
            out_data_o <= in_data_i;
            out_strb_o <= in_strb_i;
        end
        if (to_skid) begin
            skid_data <= in_data_i;
            skid_strb <= in_strb_i;
        end
    end

    assert property (@(posedge clk0) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("tx word changed before it was taken");

endmodule
